/* filelist.f */
logic/amp_pkg.sv
logic/amp_csr_axil.sv
logic/amp_reg_map.sv
logic/amp_spi_master.sv
logic/amp_seq.sv
logic/amp_frontend_top.sv
verif/amp_spi_model.sv
verif/amp_tb.sv

/* logic/amp_csr_axil.sv */
`timescale 1ns/1ns

module amp_csr_axil
    import amp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    output amp_cfg_t    cfg,
    output logic        start,
    input  amp_status_t status
);

    logic [31:0] cfg_bias;
    logic [31:0] cfg_zchk;
    logic [31:0] cfg_bw;
    logic [31:0] rd_data;
    logic        wr_en;
    logic        rd_en;

    function automatic logic [31:0] merge_strb(
        input logic [31:0] old,
        input logic [31:0] data,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    // AW and W are taken together, once the previous response is gone
    assign wr_en   = awvalid && wvalid && !bvalid;
    assign awready = wr_en;
    assign wready  = wr_en;
    assign bresp   = 2'b00;

    assign rd_en   = arvalid && !rvalid;
    assign arready = !rvalid;
    assign rresp   = 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_bias <= '0;
            cfg_zchk <= '0;
            cfg_bw   <= '0;
            bvalid   <= 1'b0;
            start    <= 1'b0;
        end else begin
            start <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_en) begin
                bvalid <= 1'b1;
                case (awaddr)
                    CSR_CTRL:     start    <= wdata[0] && !status.busy;
                    CSR_CFG_BIAS: cfg_bias <= merge_strb(cfg_bias, wdata, wstrb);
                    CSR_CFG_ZCHK: cfg_zchk <= merge_strb(cfg_zchk, wdata, wstrb);
                    CSR_CFG_BW:   cfg_bw   <= merge_strb(cfg_bw, wdata, wstrb);
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (araddr)
            CSR_STATUS:   rd_data = {16'h0, status.chip_id, status.echo_errs,
                                     status.cfg_ok, status.id_ok, status.done, status.busy};
            CSR_CFG_BIAS: rd_data = cfg_bias;
            CSR_CFG_ZCHK: rd_data = cfg_zchk;
            CSR_CFG_BW:   rd_data = cfg_bw;
            CSR_LAST_RX:  rd_data = {16'h0, status.last_rx};
            default:      rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_en) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // read data held until the handshake
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= rd_data;
        end
    end

    assign cfg.adc_bias   = cfg_bias[5:0];
    assign cfg.mux_bias   = cfg_bias[13:8];
    assign cfg.temp_sel   = cfg_bias[17:16];
    assign cfg.dsp_en     = cfg_bias[20];
    assign cfg.twos_comp  = cfg_bias[21];
    assign cfg.dsp_cutoff = cfg_bias[27:24];
    assign cfg.zchk_en    = cfg_zchk[0];
    assign cfg.zchk_scale = cfg_zchk[2:1];
    assign cfg.zchk_dac   = cfg_zchk[15:8];
    assign cfg.zchk_chan  = cfg_zchk[21:16];
    assign cfg.hi_cut     = cfg_bw[10:0];
    assign cfg.lo_cut     = cfg_bw[28:16];

endmodule

/* logic/amp_frontend_top.sv */
`timescale 1ns/1ns

module amp_frontend_top
    import amp_pkg::*;
#(
    parameter int SCLK_DIV = 2
) (
    input  logic        clk,
    input  logic        rst,

    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    output logic        sclk,
    output logic        cs,
    output logic        mosi,
    input  logic        miso
);

    amp_cfg_t    cfg;
    cfg_regs_t   regs;
    amp_status_t status;
    logic        start;
    spi_word_t   tx_word;
    logic        tx_valid;
    logic        tx_ready;
    spi_word_t   rx_word;
    logic        rx_valid;

    amp_csr_axil u_csr (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cfg     (cfg),
        .start   (start),
        .status  (status)
    );

    amp_reg_map u_map (
        .cfg  (cfg),
        .regs (regs)
    );

    amp_seq u_seq (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .regs     (regs),
        .tx_word  (tx_word),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_word  (rx_word),
        .rx_valid (rx_valid),
        .status   (status)
    );

    amp_spi_master #(
        .SCLK_DIV (SCLK_DIV)
    ) u_spi (
        .clk      (clk),
        .rst      (rst),
        .tx_word  (tx_word),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_word  (rx_word),
        .rx_valid (rx_valid),
        .sclk     (sclk),
        .cs       (cs),
        .mosi     (mosi),
        .miso     (miso)
    );

endmodule

/* logic/amp_pkg.sv */
package amp_pkg;

    typedef logic [5:0]  reg_addr_t;
    typedef logic [7:0]  reg_byte_t;
    typedef logic [15:0] spi_word_t;

    // frame is {cmd, addr, data}
    localparam logic [1:0] CMD_WRITE = 2'b10;
    localparam logic [1:0] CMD_READ  = 2'b11;

    // ROM signature lives in registers 40..44
    localparam reg_addr_t   SIG_BASE  = 6'd40;
    localparam int          SIG_LEN   = 5;
    localparam logic [39:0] SIG_BYTES = "NEURO";
    localparam reg_addr_t   ID_REG    = 6'd63;

    localparam int NUM_CFG_REGS = 14;

    typedef struct packed {
        logic [5:0]  adc_bias;
        logic [5:0]  mux_bias;
        logic [1:0]  temp_sel;
        logic        dsp_en;
        logic [3:0]  dsp_cutoff;
        logic        twos_comp;
        logic        zchk_en;
        logic [1:0]  zchk_scale;
        logic [7:0]  zchk_dac;
        logic [5:0]  zchk_chan;
        logic [10:0] hi_cut;
        logic [12:0] lo_cut;
    } amp_cfg_t;

    typedef reg_byte_t [NUM_CFG_REGS-1:0] cfg_regs_t;

    typedef struct packed {
        logic       busy;
        logic       done;
        logic       id_ok;
        logic       cfg_ok;
        reg_byte_t  chip_id;
        logic [3:0] echo_errs;
        spi_word_t  last_rx;
    } amp_status_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHECK,
        S_CHECK_FLUSH,
        S_EVAL,
        S_CONF,
        S_CONF_FLUSH,
        S_DONE
    } seq_state_t;

    localparam logic [7:0] CSR_CTRL     = 8'h00;
    localparam logic [7:0] CSR_STATUS   = 8'h04;
    localparam logic [7:0] CSR_CFG_BIAS = 8'h08;
    localparam logic [7:0] CSR_CFG_ZCHK = 8'h0C;
    localparam logic [7:0] CSR_CFG_BW   = 8'h10;
    localparam logic [7:0] CSR_LAST_RX  = 8'h14;

endpackage

/* logic/amp_reg_map.sv */
`timescale 1ns/1ns

module amp_reg_map
    import amp_pkg::*;
(
    input  amp_cfg_t  cfg,
    output cfg_regs_t regs
);

    always_comb begin
        // ADC reference and comparator bits fixed high
        regs[0]  = {2'b11, cfg.adc_bias};
        regs[1]  = {2'b00, cfg.mux_bias};
        regs[2]  = 8'h00;
        regs[3]  = {4'b0000, cfg.temp_sel, 2'b00};
        regs[4]  = {1'b0, cfg.twos_comp, 1'b0, cfg.dsp_en, cfg.dsp_cutoff};
        regs[5]  = {3'b000, cfg.zchk_scale, 2'b00, cfg.zchk_en};
        regs[6]  = cfg.zchk_dac;
        regs[7]  = {2'b00, cfg.zchk_chan};

        // upper cutoff code is split and written to both pairs
        regs[8]  = {2'b00, cfg.hi_cut[5:0]};
        regs[9]  = {3'b000, cfg.hi_cut[10:6]};
        regs[10] = {2'b00, cfg.hi_cut[5:0]};
        regs[11] = {3'b000, cfg.hi_cut[10:6]};

        // lower cutoff code
        regs[12] = {1'b0, cfg.lo_cut[6:0]};
        regs[13] = {2'b00, cfg.lo_cut[12:7]};
    end

endmodule

/* logic/amp_seq.sv */
`timescale 1ns/1ns

module amp_seq
    import amp_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  cfg_regs_t   regs,
    output spi_word_t   tx_word,
    output logic        tx_valid,
    input  logic        tx_ready,
    input  spi_word_t   rx_word,
    input  logic        rx_valid,
    output amp_status_t status
);

    typedef enum logic [1:0] {T_NONE, T_SIG, T_ID, T_ECHO} tag_kind_t;

    typedef struct packed {
        tag_kind_t kind;
        reg_byte_t exp_byte;
    } frame_tag_t;

    seq_state_t state;
    logic [3:0] idx;
    frame_tag_t new_tag;
    frame_tag_t cur_tag;
    frame_tag_t tag_q0;
    frame_tag_t tag_q1;
    logic       sig_err;
    reg_byte_t  id_byte;
    logic       fire;

    assign tx_valid = state inside {S_CHECK, S_CHECK_FLUSH, S_CONF, S_CONF_FLUSH};
    assign fire     = tx_valid && tx_ready;

    // command and tag for the frame being offered
    always_comb begin
        tx_word = {CMD_READ, ID_REG, 8'h00};
        new_tag = '{kind: T_NONE, exp_byte: 8'h00};
        case (state)
            S_CHECK: begin
                if (idx < 4'(SIG_LEN)) begin
                    tx_word = {CMD_READ, SIG_BASE + reg_addr_t'(idx), 8'h00};
                    new_tag = '{kind: T_SIG, exp_byte: SIG_BYTES[8*(SIG_LEN-1-idx) +: 8]};
                end else begin
                    new_tag = '{kind: T_ID, exp_byte: 8'h00};
                end
            end
            S_CONF: begin
                tx_word = {CMD_WRITE, reg_addr_t'(idx), regs[idx]};
                new_tag = '{kind: T_ECHO, exp_byte: regs[idx]};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            idx     <= '0;
            cur_tag <= '0;
            tag_q0  <= '0;
            tag_q1  <= '0;
            sig_err <= 1'b0;
            status  <= '0;
        end else begin
            if (fire) begin
                idx     <= idx + 1'b1;
                cur_tag <= new_tag;
            end

            // result of frame k arrives at the end of frame k+2
            if (rx_valid) begin
                status.last_rx <= rx_word;
                tag_q0         <= cur_tag;
                tag_q1         <= tag_q0;
                case (tag_q1.kind)
                    T_SIG: begin
                        if (rx_word[7:0] != tag_q1.exp_byte) begin
                            sig_err <= 1'b1;
                        end
                    end
                    T_ECHO: begin
                        if (rx_word != {8'hFF, tag_q1.exp_byte} && status.echo_errs != 4'hF) begin
                            status.echo_errs <= status.echo_errs + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end

            case (state)
                S_IDLE: begin
                    if (start) begin
                        status.busy      <= 1'b1;
                        status.done      <= 1'b0;
                        status.id_ok     <= 1'b0;
                        status.cfg_ok    <= 1'b0;
                        status.chip_id   <= '0;
                        status.echo_errs <= '0;
                        sig_err          <= 1'b0;
                        cur_tag          <= '0;
                        tag_q0           <= '0;
                        tag_q1           <= '0;
                        idx              <= '0;
                        state            <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (fire && idx == 4'd5) begin
                        idx   <= '0;
                        state <= S_CHECK_FLUSH;
                    end
                end
                S_CHECK_FLUSH: begin
                    if (fire && idx == 4'd1) begin
                        state <= S_EVAL;
                    end
                end
                S_EVAL: begin
                    // master idle means the last result is in
                    if (tx_ready) begin
                        status.id_ok   <= !sig_err;
                        status.chip_id <= id_byte;
                        idx            <= '0;
                        state          <= sig_err ? S_DONE : S_CONF;
                    end
                end
                S_CONF: begin
                    if (fire && idx == 4'(NUM_CFG_REGS - 1)) begin
                        idx   <= '0;
                        state <= S_CONF_FLUSH;
                    end
                end
                S_CONF_FLUSH: begin
                    if (fire && idx == 4'd1) begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    if (tx_ready) begin
                        status.busy   <= 1'b0;
                        status.done   <= 1'b1;
                        status.cfg_ok <= status.id_ok && status.echo_errs == 4'h0;
                        state         <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && tag_q1.kind == T_ID) begin
            id_byte <= rx_word[7:0];
        end
    end

endmodule

/* logic/amp_spi_master.sv */
`timescale 1ns/1ns

module amp_spi_master
    import amp_pkg::*;
#(
    parameter int SCLK_DIV = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  spi_word_t tx_word,
    input  logic      tx_valid,
    output logic      tx_ready,
    output spi_word_t rx_word,
    output logic      rx_valid,
    output logic      sclk,
    output logic      cs,
    output logic      mosi,
    input  logic      miso
);

    localparam int CW = $clog2(2 * SCLK_DIV);

    typedef enum logic [1:0] {M_IDLE, M_XFER, M_TAIL, M_GAP} spi_state_t;

    spi_state_t    state;
    logic [CW-1:0] cnt;
    logic [3:0]    bit_cnt;
    spi_word_t     tx_sh;
    spi_word_t     rx_sh;
    logic          half_done;

    assign tx_ready  = (state == M_IDLE);
    assign half_done = (cnt == CW'(SCLK_DIV - 1));
    assign mosi      = tx_sh[15];
    assign rx_word   = rx_sh;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= M_IDLE;
            cnt      <= '0;
            bit_cnt  <= '0;
            tx_sh    <= '0;
            sclk     <= 1'b0;
            cs       <= 1'b1;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (tx_valid) begin
                        tx_sh   <= tx_word;
                        cs      <= 1'b0;
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= M_XFER;
                    end
                end
                M_XFER: begin
                    cnt <= half_done ? '0 : cnt + 1'b1;
                    if (half_done) begin
                        sclk <= ~sclk;
                        // falling edge: next bit out
                        if (sclk) begin
                            tx_sh   <= {tx_sh[14:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd15) begin
                                state <= M_TAIL;
                            end
                        end
                    end
                end
                M_TAIL: begin
                    cnt <= cnt + 1'b1;
                    if (half_done) begin
                        cs       <= 1'b1;
                        rx_valid <= 1'b1;
                        cnt      <= '0;
                        state    <= M_GAP;
                    end
                end
                default: begin
                    // chip select high time between frames
                    cnt <= cnt + 1'b1;
                    if (cnt == CW'(2 * SCLK_DIV - 1)) begin
                        state <= M_IDLE;
                    end
                end
            endcase
        end
    end

    // sample on the rising edge
    always_ff @(posedge clk) begin
        if (state == M_XFER && half_done && !sclk) begin
            rx_sh <= {rx_sh[14:0], miso};
        end
    end

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -f filelist.f --top-module amp_tb -o amp_sim \
    > build.log 2>&1 \
    && ./obj_dir/amp_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation did not complete"; }
[ -f sim.log ] && cat sim.log
grep -q "^RESULT: PASS$" sim.log 2>/dev/null && exit 0 || exit 1

/* verif/amp_spi_model.sv */
`timescale 1ns/1ns

module amp_spi_model
    import amp_pkg::*;
(
    input  logic        sclk,
    input  logic        cs,
    input  logic        mosi,
    output logic        miso,
    input  logic [39:0] rom_sig,
    input  reg_byte_t   chip_id,
    input  logic        corrupt_en,
    input  reg_addr_t   corrupt_idx
);

    reg_byte_t mem [0:63];
    reg_addr_t wr_addr [0:63];
    reg_byte_t wr_data [0:63];
    int        wr_count;
    int        frame_count;
    spi_word_t rx_sh;
    spi_word_t tx_sh;
    spi_word_t res_new;
    spi_word_t res_old;
    reg_byte_t echo;

    function automatic reg_byte_t read_reg(input reg_addr_t a);
        int off;
        off = int'(a) - int'(SIG_BASE);
        if (off >= 0 && off < SIG_LEN) begin
            return rom_sig[8*(SIG_LEN-1-off) +: 8];
        end else if (a == ID_REG) begin
            return chip_id;
        end
        return mem[a];
    endfunction

    initial begin
        miso        = 1'b0;
        wr_count    = 0;
        frame_count = 0;
        rx_sh       = '0;
        tx_sh       = '0;
        res_new     = '0;
        res_old     = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 8'h00;
        end
        forever begin
            @(negedge cs);
            // result of the frame two back goes out now
            tx_sh = res_old;
            miso  = tx_sh[15];
            repeat (16) begin
                @(posedge sclk);
                rx_sh = {rx_sh[14:0], mosi};
                @(negedge sclk);
                tx_sh = {tx_sh[14:0], 1'b0};
                miso  = tx_sh[15];
            end
            @(posedge cs);
            frame_count++;
            res_old = res_new;
            if (rx_sh[15:14] == CMD_WRITE) begin
                echo = rx_sh[7:0];
                if (corrupt_en && rx_sh[13:8] == corrupt_idx) begin
                    echo = echo ^ 8'h01;
                end
                mem[rx_sh[13:8]] = rx_sh[7:0];
                if (wr_count < 64) begin
                    wr_addr[wr_count] = rx_sh[13:8];
                    wr_data[wr_count] = rx_sh[7:0];
                end
                wr_count++;
                res_new = {8'hFF, echo};
            end else begin
                res_new = {8'h00, read_reg(rx_sh[13:8])};
            end
        end
    end

endmodule

/* verif/amp_tb.sv */
`timescale 1ns/1ns

module amp_tb
    import amp_pkg::*;
;

    localparam int SCLK_DIV       = 2;
    localparam int TIMEOUT_CYCLES = 60000;

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        sclk;
    logic        cs;
    logic        mosi;
    logic        miso;

    logic [39:0] rom_sig;
    reg_byte_t   chip_id;
    logic        corrupt_en;
    reg_addr_t   corrupt_idx;

    logic [15:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    int          timing_errs = 0;
    int          frames_seen = 0;
    int          rise_cnt;
    int          last_rise;
    logic        cs_d;
    logic        sclk_d;

    amp_frontend_top #(.SCLK_DIV(SCLK_DIV)) DUT (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso)
    );

    amp_spi_model chip (
        .sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso),
        .rom_sig(rom_sig), .chip_id(chip_id),
        .corrupt_en(corrupt_en), .corrupt_idx(corrupt_idx)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // sclk edges per frame and sclk period, sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            cs_d     = 1'b1;
            sclk_d   = 1'b0;
            rise_cnt = 0;
        end else begin
            if (cs_d && !cs) begin
                rise_cnt = 0;
            end
            if (!cs && sclk && !sclk_d) begin
                if (rise_cnt > 0) begin
                    assert (cycle - last_rise == 2 * SCLK_DIV) else begin
                        timing_errs++;
                        $display("sclk period was %0d cycles instead of %0d",
                                 cycle - last_rise, 2 * SCLK_DIV);
                    end
                end
                rise_cnt++;
                last_rise = cycle;
            end
            if (!cs_d && cs) begin
                assert (rise_cnt == 16) else begin
                    timing_errs++;
                    $display("frame had %0d sclk rising edges instead of 16", rise_cnt);
                end
                frames_seen++;
            end
            cs_d   = cs;
            sclk_d = sclk;
        end
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // chip register value from the CSR words
    function automatic reg_byte_t expected_reg(input int n, input logic [31:0] bias,
                                               input logic [31:0] zchk, input logic [31:0] bw);
        case (n)
            0:       return {2'b11, bias[5:0]};
            1:       return {2'b00, bias[13:8]};
            3:       return {4'h0, bias[17:16], 2'b00};
            4:       return {1'b0, bias[21], 1'b0, bias[20], bias[27:24]};
            5:       return {3'b000, zchk[2:1], 2'b00, zchk[0]};
            6:       return zchk[15:8];
            7:       return {2'b00, zchk[21:16]};
            8, 10:   return {2'b00, bw[5:0]};
            9, 11:   return {3'b000, bw[10:6]};
            12:      return {1'b0, bw[22:16]};
            13:      return {2'b00, bw[28:23]};
            default: return 8'h00;
        endcase
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb = 4'hF, input int hold = 0);
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // handshake seen mid-cycle, taken at the next rising edge
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        expect_eq("wready", 32'(wready), 32'h1);
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        expect_eq("bvalid", 32'(bvalid), 32'h1);
        expect_eq("bresp", 32'(bresp), 32'h0);
        bready = 1'b1;
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             input int hold = 0);
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        // address is free once AR is accepted
        araddr  = ~addr;
        expect_eq("rvalid", 32'(rvalid), 32'h1);
        expect_eq("rresp", 32'(rresp), 32'h0);
        data = rdata;
        repeat (hold) begin
            @(posedge clk);
            #2;
            expect_eq("rdata while held", rdata, data);
        end
        rready = 1'b1;
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic wait_status_bit(input int b, output logic [31:0] st);
        do begin
            axil_read(CSR_STATUS, st);
        end while (!st[b]);
    endtask

    task automatic after_reset();
        logic [31:0] v;
        expect_eq("cs", 32'(cs), 32'h1);
        expect_eq("sclk", 32'(sclk), 32'h0);
        expect_eq("mosi", 32'(mosi), 32'h0);
        axil_read(CSR_STATUS, v);
        expect_eq("STATUS", v, 32'h0);
        axil_read(CSR_LAST_RX, v);
        expect_eq("LAST_RX", v, 32'h0);
        axil_read(CSR_CFG_BIAS, v);
        expect_eq("CFG_BIAS", v, 32'h0);
        axil_read(CSR_CFG_ZCHK, v);
        expect_eq("CFG_ZCHK", v, 32'h0);
        axil_read(CSR_CFG_BW, v);
        expect_eq("CFG_BW", v, 32'h0);
    endtask

    task automatic csr_readback();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] n;
        logic [31:0] v;
        a = lfsr_bits(32);
        b = lfsr_bits(32);
        c = lfsr_bits(32);
        axil_write(CSR_CFG_BIAS, a);
        axil_write(CSR_CFG_ZCHK, b, 4'hF, 3);
        axil_write(CSR_CFG_BW, c);
        axil_read(CSR_CFG_BIAS, v);
        expect_eq("CFG_BIAS", v, a);
        axil_read(CSR_CFG_ZCHK, v);
        expect_eq("CFG_ZCHK", v, b);
        // held read, rready low for a while
        axil_read(CSR_CFG_BW, v, 5);
        expect_eq("CFG_BW", v, c);
        n = lfsr_bits(32);
        axil_write(CSR_CFG_BIAS, n, 4'b0101);
        axil_read(CSR_CFG_BIAS, v);
        expect_eq("CFG_BIAS after partial strobe", v, {a[31:24], n[23:16], a[15:8], n[7:0]});
        axil_read(CSR_CTRL, v);
        expect_eq("CTRL", v, 32'h0);
        axil_read(8'h1C, v);
        expect_eq("unmapped", v, 32'h0);
    endtask

    task automatic full_sequence();
        logic [31:0] bias;
        logic [31:0] zchk;
        logic [31:0] bw;
        logic [31:0] st;
        logic [31:0] rx;
        int          base;
        bias = lfsr_bits(32);
        zchk = lfsr_bits(32);
        bw   = lfsr_bits(32);
        axil_write(CSR_CFG_BIAS, bias);
        axil_write(CSR_CFG_ZCHK, zchk);
        axil_write(CSR_CFG_BW, bw);
        base = chip.wr_count;
        axil_write(CSR_CTRL, 32'h1);
        wait_status_bit(1, st);
        expect_eq("STATUS.busy", 32'(st[0]), 32'h0);
        expect_eq("STATUS.id_ok", 32'(st[2]), 32'h1);
        expect_eq("STATUS.cfg_ok", 32'(st[3]), 32'h1);
        expect_eq("STATUS.echo_errs", 32'(st[7:4]), 32'h0);
        expect_eq("STATUS.chip_id", 32'(st[15:8]), 32'(chip_id));
        expect_eq("write count", chip.wr_count - base, 32'(NUM_CFG_REGS));
        for (int i = 0; i < NUM_CFG_REGS; i++) begin
            expect_eq("write addr", 32'(chip.wr_addr[base + i]), i);
            expect_eq("write data", 32'(chip.wr_data[base + i]),
                      32'(expected_reg(i, bias, zchk, bw)));
        end
        // last word in is the echo of the final register write
        axil_read(CSR_LAST_RX, rx);
        expect_eq("LAST_RX", rx, {16'h0, 8'hFF, expected_reg(NUM_CFG_REGS - 1, bias, zchk, bw)});
    endtask

    task automatic bad_signature();
        logic [31:0] st;
        int          base;
        rom_sig = SIG_BYTES ^ 40'h01;
        base    = chip.wr_count;
        axil_write(CSR_CTRL, 32'h1);
        wait_status_bit(1, st);
        expect_eq("STATUS.id_ok", 32'(st[2]), 32'h0);
        expect_eq("STATUS.cfg_ok", 32'(st[3]), 32'h0);
        expect_eq("write count", chip.wr_count - base, 32'h0);
        rom_sig = SIG_BYTES;
    endtask

    task automatic echo_fault();
        logic [31:0] st;
        int          base;
        corrupt_idx = reg_addr_t'(lfsr_bits(4) % NUM_CFG_REGS);
        corrupt_en  = 1'b1;
        base        = chip.wr_count;
        axil_write(CSR_CTRL, 32'h1);
        wait_status_bit(1, st);
        expect_eq("STATUS.id_ok", 32'(st[2]), 32'h1);
        expect_eq("STATUS.cfg_ok", 32'(st[3]), 32'h0);
        expect_eq("STATUS.echo_errs", 32'(st[7:4]), 32'h1);
        expect_eq("write count", chip.wr_count - base, 32'(NUM_CFG_REGS));
        corrupt_en = 1'b0;
    endtask

    task automatic frame_timing();
        logic [31:0] st;
        int          model_base;
        int          mon_base;
        model_base = chip.frame_count;
        mon_base   = frames_seen;
        axil_write(CSR_CTRL, 32'h1);
        wait_status_bit(0, st);
        // ignored while busy
        axil_write(CSR_CTRL, 32'h1);
        wait_status_bit(1, st);
        expect_eq("STATUS.cfg_ok", 32'(st[3]), 32'h1);
        expect_eq("model frame count", chip.frame_count - model_base, 32'd24);
        expect_eq("cs frames", frames_seen - mon_base, 32'd24);
        expect_eq("frame timing errors", timing_errs, 32'h0);
    endtask

    initial begin
        rst         = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        rom_sig     = SIG_BYTES;
        chip_id     = 8'hC5;
        corrupt_en  = 1'b0;
        corrupt_idx = '0;
        lfsr        = 16'd64172;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        after_reset();
        csr_readback();
        full_sequence();
        bad_signature();
        echo_fault();
        frame_timing();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
